// File: sources.f
+incdir+include
design/gpio_cfg_pkg.sv
design/wb_bus_if.sv
design/wb_arbiter.sv
design/cfg_ram.sv
design/chain_loader.sv
design/gpio_control_block.sv
design/gpio_cfg_top.sv
tests/tb_clock_gen.sv
tests/gpio_cfg_asserts.sv
tests/gpio_cfg_tb.sv

// File: Bender.yml
package:
  name: gpio_cfg

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/gpio_cfg_pkg.sv
      - design/wb_bus_if.sv
      - design/wb_arbiter.sv
      - design/cfg_ram.sv
      - design/chain_loader.sv
      - design/gpio_control_block.sv
      - design/gpio_cfg_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock_gen.sv
      - tests/gpio_cfg_asserts.sv
      - tests/gpio_cfg_tb.sv

// File: tests/gpio_cfg_tb.sv
// Pad config subsystem testbench driving host traffic, chain loads and pad steering
`timescale 1ns/1ps
`include "gpio_cfg_defines.svh"

module gpio_cfg_tb;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = `NUM_PADS * 16 + 40;   // Cycle budget per test

    logic                   load_data;
    logic                   int_reset;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`WB_ADR_W-1:0]   wb_adr;
    logic [`WB_DAT_W-1:0]   wb_dat_w;
    logic [`WB_DAT_W-1:0]   wb_dat_r;
    logic                   wb_ack;
    logic                   apply;
    logic                   busy;
    logic [`NUM_PADS-1:0]   mgmt_gpio_out;
    logic [`NUM_PADS-1:0]   mgmt_gpio_oeb;
    logic [`NUM_PADS-1:0]   mgmt_gpio_in;
    logic [`NUM_PADS-1:0]   user_gpio_out;
    logic [`NUM_PADS-1:0]   user_gpio_oeb;
    logic [`NUM_PADS-1:0]   user_gpio_in;
    logic [`NUM_PADS-1:0]   pad_gpio_out;
    logic [`NUM_PADS-1:0]   pad_gpio_outenb;
    logic [`NUM_PADS-1:0]   pad_gpio_in;
    logic [`CHAIN_BITS-1:0] pad_ctrl;

    integer                    seed;                 // $random state
    logic [`PAD_CTRL_BITS-1:0] model [`NUM_PADS];    // Expected RAM words
    int                        err_cnt   = 0;        // Testbench check failures
    int                        seen_errs = 0;        // Errors already charged to a test
    int                        test_num  = 0;
    int                        pass_cnt  = 0;
    int                        fail_cnt  = 0;

    tb_clock_gen u_clk (
        .load_data (load_data),
        .int_reset (int_reset)
    );

    gpio_cfg_top UUT (.*);

    // One classic transfer held until ack
    task automatic host_xfer(input logic we, input logic [`WB_ADR_W-1:0] adr,
                             input logic [`WB_DAT_W-1:0] data,
                             output logic [`WB_DAT_W-1:0] rdata);
        int waited;
        waited = 0;
        @(posedge load_data);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        do begin
            @(negedge load_data);                    // Ack stable mid cycle
            waited++;
        end while (!wb_ack && waited < TEST_CYCLES);
        if (!wb_ack) begin
            $display("Host transfer to pad %0d got no ack in %0d cycles", adr, TEST_CYCLES);
            err_cnt++;
        end
        rdata = wb_dat_r;
        @(posedge load_data);
        #1;
        wb_cyc = 1'b0;                               // Drop after the ack cycle
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_word(input int k, input logic [`WB_DAT_W-1:0] data);
        logic [`WB_DAT_W-1:0] unused;
        host_xfer(1'b1, `WB_ADR_W'(k), data, unused);
        model[k] = data[`PAD_CTRL_BITS-1:0];         // RAM keeps low 13 bits only
    endtask

    // Random words with management enable picked per pad
    task automatic write_words(input logic [`NUM_PADS-1:0] mgmt);
        logic [`WB_DAT_W-1:0] data;
        for (int k = 0; k < `NUM_PADS; k++) begin
            data    = $random(seed);
            data[0] = mgmt[k];
            write_word(k, data);
        end
    endtask

    task automatic read_check(input int k);
        logic [`WB_DAT_W-1:0] rd;
        logic [`WB_DAT_W-1:0] exp;
        exp = {{(`WB_DAT_W - `PAD_CTRL_BITS){1'b0}}, model[k]};
        host_xfer(1'b0, `WB_ADR_W'(k), '0, rd);
        assert (rd == exp) else begin
            $display("** Error at %0t ns: wb_dat_r expected %h actual %h", $time, exp, rd);
            err_cnt++;
        end
    endtask

    task automatic pulse_apply;
        @(posedge load_data);
        #1;
        apply = 1'b1;
        @(posedge load_data);
        #1;
        apply = 1'b0;
    endtask

    task automatic wait_idle;
        int waited;
        waited = 0;
        while (busy && waited < TEST_CYCLES) begin
            @(negedge load_data);
            waited++;
        end
        if (busy) begin
            $display("Chain load still busy after %0d cycles", TEST_CYCLES);
            err_cnt++;
        end
    endtask

    // Random traffic on management, user and pad inputs
    task automatic drive_sides(input int cycles);
        logic [31:0] r;
        repeat (cycles) begin
            @(posedge load_data);
            #1;
            r = $random(seed);
            mgmt_gpio_out = r[0 +: `NUM_PADS];
            mgmt_gpio_oeb = r[`NUM_PADS +: `NUM_PADS];
            user_gpio_out = r[2*`NUM_PADS +: `NUM_PADS];
            user_gpio_oeb = r[3*`NUM_PADS +: `NUM_PADS];
            pad_gpio_in   = r[4*`NUM_PADS +: `NUM_PADS];
        end
    endtask

    task automatic end_test(input string name);
        int total;
        int errs;
        total     = err_cnt + int'(UUT.u_asserts.fail_cnt);
        errs      = total - seen_errs;
        seen_errs = total;
        test_num++;
        if (errs == 0) begin
            pass_cnt++;
            $display("Test %0d %s: ok", test_num, name);
        end else begin
            fail_cnt++;
            $display("Test %0d %s: %0d errors", test_num, name, errs);
        end
    endtask

    initial begin
        seed          = 32'h5b55;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        apply         = 1'b0;
        mgmt_gpio_out = '0;
        mgmt_gpio_oeb = '0;
        user_gpio_out = '0;
        user_gpio_oeb = '0;
        pad_gpio_in   = '0;
        for (int k = 0; k < `NUM_PADS; k++) begin
            model[k] = '0;
        end
        @(negedge int_reset);
        drive_sides(6);                              // Reset values give management the pads
        end_test("reset state");
        write_words(4'b1010);
        for (int k = 0; k < `NUM_PADS; k++) begin
            read_check(k);
        end
        drive_sides(4);                              // Config must not move yet
        end_test("host write and read back");
        pulse_apply();
        wait_idle();
        drive_sides(2);
        end_test("apply loads chain");
        drive_sides(8);                              // Odd pads management and even pads user
        write_words(4'b0101);
        pulse_apply();
        wait_idle();
        drive_sides(8);                              // Ownership swapped on every pad
        end_test("management and user steering");
        write_words(4'b0011);
        pulse_apply();
        for (int k = 0; k < `NUM_PADS; k++) begin
            read_check(k);                           // Contends with loader reads
        end
        pulse_apply();                               // Ignored while loader still busy
        wait_idle();
        drive_sides(10);
        end_test("host traffic during load");
        write_word(2, $random(seed));
        read_check(2);
        drive_sides(12);
        repeat (2) @(posedge load_data);
        end_test("bus and config invariants");
        $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog budget covers every test plus reset
    initial begin
        repeat (NUM_TESTS * TEST_CYCLES + 8) @(posedge load_data);
        $display("Watchdog expired, the run timed out before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: tests/gpio_cfg_asserts.sv
// Bound checker for the pad config subsystem, host word shadow and bus/chain rules
`timescale 1ns/1ps
`include "gpio_cfg_defines.svh"

module gpio_cfg_asserts (
    input logic                   load_data,
    input logic                   int_reset,
    input logic                   wb_cyc,
    input logic                   wb_stb,
    input logic                   wb_we,
    input logic [`WB_ADR_W-1:0]   wb_adr,
    input logic [`WB_DAT_W-1:0]   wb_dat_w,
    input logic [`WB_DAT_W-1:0]   wb_dat_r,
    input logic                   wb_ack,
    input logic                   apply,
    input logic                   busy,
    input logic [`NUM_PADS-1:0]   mgmt_gpio_out,
    input logic [`NUM_PADS-1:0]   mgmt_gpio_oeb,
    input logic [`NUM_PADS-1:0]   mgmt_gpio_in,
    input logic [`NUM_PADS-1:0]   user_gpio_out,
    input logic [`NUM_PADS-1:0]   user_gpio_oeb,
    input logic [`NUM_PADS-1:0]   user_gpio_in,
    input logic [`NUM_PADS-1:0]   pad_gpio_out,
    input logic [`NUM_PADS-1:0]   pad_gpio_outenb,
    input logic [`NUM_PADS-1:0]   pad_gpio_in,
    input logic [`CHAIN_BITS-1:0] pad_ctrl
);

    // Input only pad, output off, management owned
    localparam logic [`PAD_CTRL_BITS-1:0] RESET_WORD = {
        `DM_INIT, `TRIP_INIT, `SLOW_INIT, `APOL_INIT, `ASEL_INIT, `AENA_INIT,
        `IB_INIT, `IENB_INIT, `HOLD_INIT, `OENB_INIT, `MGMT_INIT
    };

    int unsigned               fail_cnt = 0;         // Failed assertion count
    logic [`PAD_CTRL_BITS-1:0] shadow [`NUM_PADS];   // Last host word per pad
    logic [`CHAIN_BITS-1:0]    shadow_flat;          // Same layout as pad_ctrl

    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            for (int i = 0; i < `NUM_PADS; i++) begin
                shadow[i] <= '0;                     // RAM starts cleared
            end
        end else if (wb_ack && wb_we) begin
            shadow[wb_adr] <= wb_dat_w[`PAD_CTRL_BITS-1:0]; // Completed host write
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_PADS; i++) begin
            shadow_flat[i*`PAD_CTRL_BITS +: `PAD_CTRL_BITS] = shadow[i];
        end
    end

    a_reset_state: assert property (@(posedge load_data)
        $fell(int_reset) |-> pad_ctrl == {`NUM_PADS{RESET_WORD}} && !busy && !wb_ack)
        else begin
            $error("Cells, busy or ack not in reset state after reset");
            fail_cnt++;
        end

    a_ack_in_cycle: assert property (@(posedge load_data) disable iff (int_reset)
        wb_ack |-> wb_cyc && wb_stb)
        else begin
            $error("Host ack seen without cyc and stb");
            fail_cnt++;
        end

    a_ack_single: assert property (@(posedge load_data) disable iff (int_reset)
        wb_ack |=> !wb_ack)
        else begin
            $error("Host ack held longer than one cycle");
            fail_cnt++;
        end

    // Read data always matches the last host write to that pad
    a_read_data: assert property (@(posedge load_data) disable iff (int_reset)
        wb_ack && !wb_we |->
            wb_dat_r == {{(`WB_DAT_W - `PAD_CTRL_BITS){1'b0}}, shadow[wb_adr]})
        else begin
            $error("Host read data differs from last written word");
            fail_cnt++;
        end

    a_busy_start: assert property (@(posedge load_data) disable iff (int_reset)
        apply && !busy |=> busy)
        else begin
            $error("Busy did not rise the cycle after apply");
            fail_cnt++;
        end

    a_busy_cause: assert property (@(posedge load_data) disable iff (int_reset)
        $rose(busy) |-> $past(apply && !busy))
        else begin
            $error("Busy rose without an accepted apply");
            fail_cnt++;
        end

    a_chain_load: assert property (@(posedge load_data) disable iff (int_reset)
        $fell(busy) |-> pad_ctrl == shadow_flat)
        else begin
            $error("Pad config after load differs from host words");
            fail_cnt++;
        end

    a_cfg_stable: assert property (@(posedge load_data) disable iff (int_reset)
        !busy |=> $stable(pad_ctrl))
        else begin
            $error("Pad config changed while loader idle");
            fail_cnt++;
        end

    for (genvar k = 0; k < `NUM_PADS; k++) begin : g_steer
        a_mgmt_owns: assert property (@(posedge load_data) disable iff (int_reset)
            pad_ctrl[k*`PAD_CTRL_BITS] |->
                pad_gpio_out[k] == mgmt_gpio_out[k] && pad_gpio_outenb[k] == mgmt_gpio_oeb[k]
                && mgmt_gpio_in[k] == pad_gpio_in[k] && !user_gpio_in[k])
            else begin
                $error("Pad %0d not steered to the management side", k);
                fail_cnt++;
            end

        a_user_owns: assert property (@(posedge load_data) disable iff (int_reset)
            !pad_ctrl[k*`PAD_CTRL_BITS] |->
                pad_gpio_out[k] == user_gpio_out[k] && pad_gpio_outenb[k] == user_gpio_oeb[k]
                && user_gpio_in[k] == pad_gpio_in[k] && !mgmt_gpio_in[k])
            else begin
                $error("Pad %0d not steered to the user side", k);
                fail_cnt++;
            end
    end

endmodule

bind gpio_cfg_top gpio_cfg_asserts u_asserts (.*);

// File: tests/tb_clock_gen.sv
// Testbench clock and reset source, 4 ns clock with reset held for 8 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic load_data,
    output logic int_reset
);

    initial begin
        load_data = 1'b0;
        forever #2 load_data = ~load_data;     // 4 ns period
    end

    initial begin
        int_reset = 1'b1;
        repeat (8) @(posedge load_data);       // Reset over first 8 cycles
        #1 int_reset = 1'b0;
    end

endmodule

// File: design/gpio_cfg_top.sv
// Pad config subsystem top: host port, arbiter, config RAM, loader, cell chain
`timescale 1ns/1ps
`include "gpio_cfg_defines.svh"

module gpio_cfg_top (
    input  logic                   load_data,
    input  logic                   int_reset,
    input  logic                   wb_cyc,          // Host Wishbone
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`WB_ADR_W-1:0]   wb_adr,
    input  logic [`WB_DAT_W-1:0]   wb_dat_w,
    output logic [`WB_DAT_W-1:0]   wb_dat_r,
    output logic                   wb_ack,
    input  logic                   apply,           // Start chain load
    output logic                   busy,
    input  logic [`NUM_PADS-1:0]   mgmt_gpio_out,   // Management side
    input  logic [`NUM_PADS-1:0]   mgmt_gpio_oeb,
    output logic [`NUM_PADS-1:0]   mgmt_gpio_in,
    input  logic [`NUM_PADS-1:0]   user_gpio_out,   // User side
    input  logic [`NUM_PADS-1:0]   user_gpio_oeb,
    output logic [`NUM_PADS-1:0]   user_gpio_in,
    output logic [`NUM_PADS-1:0]   pad_gpio_out,    // Pad side
    output logic [`NUM_PADS-1:0]   pad_gpio_outenb,
    input  logic [`NUM_PADS-1:0]   pad_gpio_in,
    output logic [`CHAIN_BITS-1:0] pad_ctrl         // Pad k in slice k
);

    wb_bus_if host_bus ();
    wb_bus_if loader_bus ();
    wb_bus_if ram_bus ();

    logic                serial_data;  // Loader into cell 0
    logic                shift_en;
    logic                load;
    logic [`NUM_PADS:0]  chain;        // Bit k feeds cell k, top bit is chain end

    // Host ports onto the internal bus
    assign host_bus.cyc   = wb_cyc;
    assign host_bus.stb   = wb_stb;
    assign host_bus.we    = wb_we;
    assign host_bus.adr   = wb_adr;
    assign host_bus.dat_w = wb_dat_w;
    assign wb_dat_r       = host_bus.dat_r;
    assign wb_ack         = host_bus.ack;

    assign chain[0] = serial_data;

    wb_arbiter u_arbiter (
        .load_data (load_data),
        .int_reset (int_reset),
        .host      (host_bus.slave),
        .loader    (loader_bus.slave),
        .mem       (ram_bus.master)
    );

    cfg_ram u_ram (
        .load_data (load_data),
        .int_reset (int_reset),
        .bus       (ram_bus.slave)
    );

    chain_loader u_loader (
        .load_data   (load_data),
        .int_reset   (int_reset),
        .apply       (apply),
        .busy        (busy),
        .bus         (loader_bus.master),
        .serial_data (serial_data),
        .shift_en    (shift_en),
        .load        (load)
    );

    for (genvar k = 0; k < `NUM_PADS; k++) begin : g_cell
        gpio_control_block u_cell (
            .load_data       (load_data),
            .int_reset       (int_reset),
            .serial_in       (chain[k]),
            .shift_en        (shift_en),
            .load            (load),
            .serial_out      (chain[k+1]),
            .mgmt_gpio_out   (mgmt_gpio_out[k]),
            .mgmt_gpio_oeb   (mgmt_gpio_oeb[k]),
            .mgmt_gpio_in    (mgmt_gpio_in[k]),
            .user_gpio_out   (user_gpio_out[k]),
            .user_gpio_oeb   (user_gpio_oeb[k]),
            .user_gpio_in    (user_gpio_in[k]),
            .pad_gpio_out    (pad_gpio_out[k]),
            .pad_gpio_outenb (pad_gpio_outenb[k]),
            .pad_gpio_in     (pad_gpio_in[k]),
            .pad_cfg         (pad_ctrl[k*`PAD_CTRL_BITS +: `PAD_CTRL_BITS])
        );
    end

endmodule

// File: design/gpio_control_block.sv
// GPIO pad cell: serial shift stage, latched pad config, management/user steering
`timescale 1ns/1ps
`include "gpio_cfg_defines.svh"

module gpio_control_block (
    input  logic                   load_data,
    input  logic                   int_reset,
    input  logic                   serial_in,       // From previous cell
    input  logic                   shift_en,        // Advance shift stage
    input  logic                   load,            // Latch shift stage
    output logic                   serial_out,      // To next cell
    input  logic                   mgmt_gpio_out,   // Management to pad
    input  logic                   mgmt_gpio_oeb,   // Management output disable
    output logic                   mgmt_gpio_in,    // Pad to management
    input  logic                   user_gpio_out,   // User to pad
    input  logic                   user_gpio_oeb,   // User output disable
    output logic                   user_gpio_in,    // Pad to user
    output logic                   pad_gpio_out,    // Pad output data
    output logic                   pad_gpio_outenb, // Pad output disable
    input  logic                   pad_gpio_in,     // Pad input data
    output gpio_cfg_pkg::pad_cfg_t pad_cfg          // Latched config
);

    logic [`PAD_CTRL_BITS-1:0] shift_q; // Serial stage

    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            shift_q <= '0;
        end else if (shift_en) begin
            shift_q <= {shift_q[`PAD_CTRL_BITS-2:0], serial_in}; // MSB leaves first
        end
    end

    assign serial_out = shift_q[`PAD_CTRL_BITS-1];

    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            pad_cfg.mgmt_ena    <= `MGMT_INIT;  // Management control at start
            pad_cfg.outenb      <= `OENB_INIT;
            pad_cfg.holdover    <= `HOLD_INIT;
            pad_cfg.inenb       <= `IENB_INIT;
            pad_cfg.ib_mode_sel <= `IB_INIT;
            pad_cfg.ana_en      <= `AENA_INIT;
            pad_cfg.ana_sel     <= `ASEL_INIT;
            pad_cfg.ana_pol     <= `APOL_INIT;
            pad_cfg.slow_sel    <= `SLOW_INIT;
            pad_cfg.vtrip_sel   <= `TRIP_INIT;
            pad_cfg.dm          <= `DM_INIT;
        end else if (load) begin
            pad_cfg <= shift_q;                 // All cells latch together
        end
    end

    // Owner side drives the pad
    assign pad_gpio_out    = pad_cfg.mgmt_ena ? mgmt_gpio_out : user_gpio_out;
    assign pad_gpio_outenb = pad_cfg.mgmt_ena ? mgmt_gpio_oeb : user_gpio_oeb;

    // Side without control reads zero
    assign mgmt_gpio_in = pad_cfg.mgmt_ena ? pad_gpio_in : 1'b0;
    assign user_gpio_in = pad_cfg.mgmt_ena ? 1'b0 : pad_gpio_in;

endmodule

// File: design/chain_loader.sv
// Chain loader: reads every pad word over Wishbone, shifts it into the chain, pulses load
`timescale 1ns/1ps
`include "gpio_cfg_defines.svh"

module chain_loader (
    input  logic     load_data,
    input  logic     int_reset,
    input  logic     apply,        // Start a chain load
    output logic     busy,         // Load in progress
    wb_bus_if.master bus,          // Read port toward arbiter
    output logic     serial_data,  // Into cell 0
    output logic     shift_en,     // Chain advances one bit
    output logic     load          // All cells latch
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_SHIFT,
        ST_LATCH
    } state_t;

    state_t                  state_q;
    logic [`WB_ADR_W-1:0]    pad_cnt;   // Pad being read, counts down
    logic [3:0]              bit_cnt;   // Bits shifted of current word
    gpio_cfg_pkg::pad_cfg_t  word_q;    // Word being shifted out

    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            state_q <= ST_IDLE;
            pad_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (apply) begin
                        state_q <= ST_READ;
                        pad_cnt <= `WB_ADR_W'(`NUM_PADS - 1); // Last pad goes first
                    end
                end
                ST_READ: begin
                    if (bus.ack) begin
                        state_q <= ST_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                ST_SHIFT: begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'(`PAD_CTRL_BITS - 1)) begin
                        if (pad_cnt == '0) begin
                            state_q <= ST_LATCH;   // Whole chain filled
                        end else begin
                            state_q <= ST_READ;
                            pad_cnt <= pad_cnt - 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= ST_IDLE;            // Latch lasts one cycle
                end
            endcase
        end
    end

    // Word capture and MSB-first shift
    always_ff @(posedge load_data) begin
        if (state_q == ST_READ && bus.ack) begin
            word_q <= bus.dat_r[`PAD_CTRL_BITS-1:0];
        end else if (state_q == ST_SHIFT) begin
            word_q <= {word_q[`PAD_CTRL_BITS-2:0], 1'b0};
        end
    end

    assign busy        = (state_q != ST_IDLE);    // Apply while busy ignored
    assign shift_en    = (state_q == ST_SHIFT);
    assign load        = (state_q == ST_LATCH);
    assign serial_data = word_q[`PAD_CTRL_BITS-1];

    // Read only master
    assign bus.cyc   = (state_q == ST_READ);
    assign bus.stb   = (state_q == ST_READ);
    assign bus.we    = 1'b0;
    assign bus.adr   = pad_cnt;
    assign bus.dat_w = '0;

endmodule

// File: design/cfg_ram.sv
// Config RAM, Wishbone slave with one 13-bit word per pad
`timescale 1ns/1ps
`include "gpio_cfg_defines.svh"

module cfg_ram (
    input  logic    load_data,
    input  logic    int_reset,
    wb_bus_if.slave bus
);

    logic [`PAD_CTRL_BITS-1:0] words [`NUM_PADS];  // One word per pad
    logic                      ack_q;              // Registered ack
    logic                      req;                // New transfer seen

    // No new request in the ack cycle, keeps ack to one cycle
    assign req = bus.cyc && bus.stb && !ack_q;

    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            ack_q <= 1'b0;
            for (int i = 0; i < `NUM_PADS; i++) begin
                words[i] <= '0;                    // Contents start at zero
            end
        end else begin
            ack_q <= req;
            if (req && bus.we) begin
                words[bus.adr] <= bus.dat_w[`PAD_CTRL_BITS-1:0]; // Upper bits dropped
            end
        end
    end

    assign bus.ack = ack_q;

    // Address held until ack, so data is valid with ack
    assign bus.dat_r = {{(`WB_DAT_W - `PAD_CTRL_BITS){1'b0}}, words[bus.adr]};

endmodule

// File: design/wb_arbiter.sv
// Two-master Wishbone arbiter, host first, grant held for the whole cycle
`timescale 1ns/1ps
`include "gpio_cfg_defines.svh"

module wb_arbiter (
    input  logic     load_data,
    input  logic     int_reset,
    wb_bus_if.slave  host,       // External host master
    wb_bus_if.slave  loader,     // Chain loader master
    wb_bus_if.master mem         // Toward config RAM
);

    gpio_cfg_pkg::wb_owner_t owner_q;   // Last granted master
    gpio_cfg_pkg::wb_owner_t grant;     // Grant this cycle
    logic                    owner_cyc; // Current owner still in a cycle

    assign owner_cyc = (owner_q == gpio_cfg_pkg::OWNER_HOST) ? host.cyc : loader.cyc;

    // Grant is combinational so no cycle is added
    always_comb begin
        if (owner_cyc) begin
            grant = owner_q;                       // Hold through the cycle
        end else if (host.cyc) begin
            grant = gpio_cfg_pkg::OWNER_HOST;      // Host wins on free bus
        end else if (loader.cyc) begin
            grant = gpio_cfg_pkg::OWNER_LOADER;
        end else begin
            grant = owner_q;                       // Idle, keep last
        end
    end

    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            owner_q <= gpio_cfg_pkg::OWNER_HOST;
        end else begin
            owner_q <= grant;                      // Only moves when owner idle
        end
    end

    // Request mux toward the RAM
    always_comb begin
        if (grant == gpio_cfg_pkg::OWNER_HOST) begin
            mem.cyc   = host.cyc;
            mem.stb   = host.stb;
            mem.we    = host.we;
            mem.adr   = host.adr;
            mem.dat_w = host.dat_w;
        end else begin
            mem.cyc   = loader.cyc;
            mem.stb   = loader.stb;
            mem.we    = loader.we;
            mem.adr   = loader.adr;
            mem.dat_w = loader.dat_w;
        end
    end

    // Loser sees no ack and stalls
    assign host.ack     = mem.ack && (grant == gpio_cfg_pkg::OWNER_HOST);
    assign loader.ack   = mem.ack && (grant == gpio_cfg_pkg::OWNER_LOADER);
    assign host.dat_r   = (grant == gpio_cfg_pkg::OWNER_HOST) ? mem.dat_r : '0;
    assign loader.dat_r = (grant == gpio_cfg_pkg::OWNER_LOADER) ? mem.dat_r : '0;

endmodule

// File: design/wb_bus_if.sv
// Wishbone classic bus bundle with master and slave views
`timescale 1ns/1ps
`include "gpio_cfg_defines.svh"

interface wb_bus_if;

    logic                 cyc;    // Cycle in progress
    logic                 stb;    // Transfer strobe
    logic                 we;     // Write when high
    logic [`WB_ADR_W-1:0] adr;    // Word address
    logic [`WB_DAT_W-1:0] dat_w;  // Master to slave data
    logic [`WB_DAT_W-1:0] dat_r;  // Slave to master data
    logic                 ack;    // One cycle transfer done

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// File: design/gpio_cfg_pkg.sv
// Pad config package: pad configuration word layout and bus owner type
`include "gpio_cfg_defines.svh"

package gpio_cfg_pkg;

    // Pad word, first field is the MSB of the packed struct
    typedef struct packed {
        logic [2:0] dm;          // Bits 12:10, drive mode
        logic       vtrip_sel;   // Bit 9
        logic       slow_sel;    // Bit 8
        logic       ana_pol;     // Bit 7
        logic       ana_sel;     // Bit 6
        logic       ana_en;      // Bit 5
        logic       ib_mode_sel; // Bit 4
        logic       inenb;       // Bit 3, input disable
        logic       holdover;    // Bit 2
        logic       outenb;      // Bit 1, output disable
        logic       mgmt_ena;    // Bit 0, management owns pad
    } pad_cfg_t;

    // Which master currently holds the RAM bus
    typedef enum logic {
        OWNER_HOST   = 1'b0,     // External host
        OWNER_LOADER = 1'b1      // Chain loader
    } wb_owner_t;

endpackage

// File: include/gpio_cfg_defines.svh
// Pad config subsystem constants: pad count, chain width, bus widths, pad reset values
`ifndef GPIO_CFG_DEFINES_SVH
`define GPIO_CFG_DEFINES_SVH

`define NUM_PADS       4                                  // Cells in the chain
`define PAD_CTRL_BITS  13                                 // Config bits per pad
`define CHAIN_BITS     (`NUM_PADS * `PAD_CTRL_BITS)       // Flattened pad_ctrl width

`define WB_DAT_W       32                                 // Bus data width
`define WB_ADR_W       2                                  // Word address, selects the pad

// Pad field reset values, input only with output disabled
`define HOLD_INIT      1'b0                               // No holdover latch
`define SLOW_INIT      1'b0                               // Fast slew
`define TRIP_INIT      1'b0                               // CMOS trip point
`define IB_INIT        1'b0                               // CMOS input buffer
`define IENB_INIT      1'b0                               // Input enabled
`define OENB_INIT      1'b1                               // Output disabled
`define DM_INIT        3'b001                             // Drive mode input only
`define AENA_INIT      1'b0                               // Digital path
`define ASEL_INIT      1'b0                               // Don't care, analog off
`define APOL_INIT      1'b0                               // Don't care, analog off
`define MGMT_INIT      1'b1                               // Management owns the pad

`endif
